// ==== cache_config.svh ====
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// data cache geometry
// two ways per set, two words per block
`define DSETS 8

// instruction cache geometry
// direct mapped, one word per block
`define ISETS 16

// address field widths
// byte offset is always two bits
`define TAGW  26   // data tag
`define ITAGW 26   // instruction tag

`define DIDXW 3    // log2 of DSETS
`define IIDXW 4    // log2 of ISETS

// data address also carries one block offset bit,
// so TAGW + DIDXW + 1 + 2 is 32
// instruction address has no block offset,
// so ITAGW + IIDXW + 2 is 32

`endif

// ==== cacheTypesPkg.sv ====
`include "cache_config.svh"

package cacheTypesPkg;

   typedef logic [31:0] word_t;
   typedef logic [31:0] addr_t;

   // address fields
   typedef logic [`TAGW-1:0]  dTag_t;
   typedef logic [`ITAGW-1:0] iTag_t;
   typedef logic [`DIDXW-1:0] dIdx_t;
   typedef logic [`IIDXW-1:0] iIdx_t;

   typedef struct packed {
      dTag_t      tag;
      dIdx_t      idx;
      logic       blkoff;   // word within block
      logic [1:0] bytoff;
   } dAddr_t;

   typedef struct packed {
      iTag_t      tag;
      iIdx_t      idx;
      logic [1:0] bytoff;
   } iAddr_t;

   // cache to arbiter
   typedef struct packed {
      logic  ren;
      logic  wen;
      addr_t addr;
      word_t store;
   } cacheReq_t;

   // arbiter back to cache
   typedef struct packed {
      logic  busWait;   // low only in the completing cycle
      word_t load;
   } cacheResp_t;

   typedef enum logic [1:0] {ramFree, ramBusy, ramAccess} ramState_t;

   typedef enum logic [2:0] {dIdle, writeBack0, writeBack1, fetch0, fetch1} dState_t;
   typedef enum logic {iIdle, iFetch} iState_t;

endpackage

// ==== dataCache.sv ====
`include "cache_config.svh"

module dataCache (
   input  logic                      CLK,
   input  logic                      nRST,
   input  logic                      dmemREN,
   input  logic                      dmemWEN,
   input  cacheTypesPkg::addr_t      dmemAddr,
   input  cacheTypesPkg::word_t      dmemStore,
   output logic                      dhit,
   output cacheTypesPkg::word_t      dmemLoad,
   output cacheTypesPkg::cacheReq_t  dReq,
   input  cacheTypesPkg::cacheResp_t dResp
);
   import cacheTypesPkg::*;

   dAddr_t            reqAddr;
   dIdx_t             setIdx;
   dTag_t             tagMem  [2][`DSETS];
   word_t             dataMem [2][`DSETS][2];
   logic [`DSETS-1:0] valid [2];
   logic [`DSETS-1:0] dirty [2];
   logic [`DSETS-1:0] lru;          // way to evict next
   logic [1:0]        wayHit;
   logic              hitWay;
   logic              victim;
   logic              request;
   logic              accessDone;
   dState_t           state;
   dState_t           nextState;
   dAddr_t            busAddr;

   assign reqAddr    = dmemAddr;
   assign setIdx     = reqAddr.idx;
   assign request    = dmemREN | dmemWEN;
   assign accessDone = ~dResp.busWait;
   assign victim     = lru[setIdx];

   // tag compare on both ways
   assign wayHit[0] = valid[0][setIdx] && (tagMem[0][setIdx] == reqAddr.tag);
   assign wayHit[1] = valid[1][setIdx] && (tagMem[1][setIdx] == reqAddr.tag);
   assign hitWay    = wayHit[1];

   assign dhit     = request && (|wayHit);
   assign dmemLoad = dataMem[hitWay][setIdx][reqAddr.blkoff];

   always_comb
   begin
      nextState = state;
      case (state)
         dIdle:
            if (request && !dhit)
               nextState = (valid[victim][setIdx] && dirty[victim][setIdx]) ?
                           writeBack0 : fetch0;
         writeBack0:
            if (accessDone)
               nextState = writeBack1;
         writeBack1:
            if (accessDone)
               nextState = fetch0;
         fetch0:
            if (accessDone)
               nextState = fetch1;
         fetch1:
            if (accessDone)
               nextState = dIdle;   // set valid now, hits next cycle
         default:
            nextState = dIdle;
      endcase
   end

   // one bus word per state
   always_comb
   begin
      dReq        = '0;
      busAddr     = '0;
      busAddr.idx = setIdx;
      case (state)
         writeBack0, writeBack1:
         begin
            busAddr.tag    = tagMem[victim][setIdx];   // victim's old block
            busAddr.blkoff = (state == writeBack1);
            dReq.wen       = 1'b1;
            dReq.store     = dataMem[victim][setIdx][busAddr.blkoff];
         end
         fetch0, fetch1:
         begin
            busAddr.tag    = reqAddr.tag;
            busAddr.blkoff = (state == fetch1);
            dReq.ren       = 1'b1;
         end
         default:
         begin
            dReq.ren = 1'b0;
         end
      endcase
      dReq.addr = busAddr;
   end

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
         state <= dIdle;
      else
         state <= nextState;
   end

   // valid, dirty and lru bits
   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         valid <= '{default: '0};
         dirty <= '{default: '0};
         lru   <= '0;
      end
      else
      begin
         if (dhit)
         begin
            lru[setIdx] <= ~hitWay;   // other way is now least recent
            if (dmemWEN)
               dirty[hitWay][setIdx] <= 1'b1;
         end
         if (accessDone && state == fetch0)
            valid[victim][setIdx] <= 1'b0;   // block half overwritten
         if (accessDone && state == fetch1)
         begin
            valid[victim][setIdx] <= 1'b1;
            dirty[victim][setIdx] <= 1'b0;
         end
      end
   end

   // tag and data arrays
   always_ff @(posedge CLK)
   begin
      if (dhit && dmemWEN)
         dataMem[hitWay][setIdx][reqAddr.blkoff] <= dmemStore;
      if (accessDone && state == fetch0)
         dataMem[victim][setIdx][0] <= dResp.load;
      if (accessDone && state == fetch1)
      begin
         dataMem[victim][setIdx][1] <= dResp.load;
         tagMem[victim][setIdx]     <= reqAddr.tag;
      end
   end

endmodule

// ==== instrCache.sv ====
`include "cache_config.svh"

module instrCache (
   input  logic                      CLK,
   input  logic                      nRST,
   input  logic                      imemREN,
   input  cacheTypesPkg::addr_t      imemAddr,
   output logic                      ihit,
   output cacheTypesPkg::word_t      imemLoad,
   output cacheTypesPkg::cacheReq_t  iReq,
   input  cacheTypesPkg::cacheResp_t iResp
);
   import cacheTypesPkg::*;

   iAddr_t            reqAddr;
   iIdx_t             setIdx;
   iTag_t             tagMem  [`ISETS];
   word_t             dataMem [`ISETS];
   logic [`ISETS-1:0] valid;
   logic              fillDone;
   iState_t           state;

   assign reqAddr  = imemAddr;
   assign setIdx   = reqAddr.idx;
   assign fillDone = (state == iFetch) && !iResp.busWait;

   assign ihit     = imemREN && valid[setIdx] && (tagMem[setIdx] == reqAddr.tag);
   assign imemLoad = dataMem[setIdx];

   // read of the missing word, aligned
   always_comb
   begin
      iReq             = '0;
      iReq.ren         = (state == iFetch);
      iReq.addr        = {reqAddr.tag, reqAddr.idx, 2'b00};
   end

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         state <= iIdle;
         valid <= '0;
      end
      else
      begin
         case (state)
            iIdle:
               if (imemREN && !ihit)
                  state <= iFetch;
            iFetch:
               if (fillDone)
               begin
                  state          <= iIdle;   // hits next cycle
                  valid[setIdx]  <= 1'b1;
               end
            default:
               state <= iIdle;
         endcase
      end
   end

   always_ff @(posedge CLK)
   begin
      if (fillDone)
      begin
         tagMem[setIdx]  <= reqAddr.tag;
         dataMem[setIdx] <= iResp.load;
      end
   end

endmodule

// ==== memoryControl.sv ====
module memoryControl (
   input  logic                      CLK,
   input  logic                      nRST,
   input  cacheTypesPkg::cacheReq_t  dReq,
   input  cacheTypesPkg::cacheReq_t  iReq,
   output cacheTypesPkg::cacheResp_t dResp,
   output cacheTypesPkg::cacheResp_t iResp,
   output logic                      ramREN,
   output logic                      ramWEN,
   output cacheTypesPkg::addr_t      ramAddr,
   output cacheTypesPkg::word_t      ramStore,
   input  cacheTypesPkg::word_t      ramLoad,
   input  cacheTypesPkg::ramState_t  ramState
);
   import cacheTypesPkg::*;

   typedef enum logic [1:0] {ownNone, ownData, ownInstr} owner_t;

   owner_t    owner;   // holder of an access still in flight
   owner_t    grant;
   cacheReq_t busReq;
   logic      dWants;
   logic      iWants;
   logic      done;

   assign dWants = dReq.ren | dReq.wen;
   assign iWants = iReq.ren | iReq.wen;
   assign done   = (ramState == ramAccess);

   // data cache first, but never break an open access
   always_comb
   begin
      if (owner != ownNone)
         grant = owner;
      else if (dWants)
         grant = ownData;
      else if (iWants)
         grant = ownInstr;
      else
         grant = ownNone;
   end

   always_comb
   begin
      case (grant)
         ownData:  busReq = dReq;
         ownInstr: busReq = iReq;
         default:  busReq = '0;
      endcase
   end

   assign ramREN   = busReq.ren;
   assign ramWEN   = busReq.wen;
   assign ramAddr  = busReq.addr;
   assign ramStore = busReq.store;

   // only the owner sees its access finish
   assign dResp.busWait = !((grant == ownData) && done);
   assign dResp.load    = (grant == ownData) ? ramLoad : '0;
   assign iResp.busWait = !((grant == ownInstr) && done);
   assign iResp.load    = (grant == ownInstr) ? ramLoad : '0;

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
         owner <= ownNone;
      else if (done)
         owner <= ownNone;   // released on ramAccess
      else
         owner <= grant;
   end

endmodule

// ==== cacheSystem.sv ====
module cacheSystem (
   input  logic                     CLK,
   input  logic                     nRST,
   // processor data port
   input  logic                     dmemREN,
   input  logic                     dmemWEN,
   input  cacheTypesPkg::addr_t     dmemAddr,
   input  cacheTypesPkg::word_t     dmemStore,
   output logic                     dhit,
   output cacheTypesPkg::word_t     dmemLoad,
   // processor instruction port
   input  logic                     imemREN,
   input  cacheTypesPkg::addr_t     imemAddr,
   output logic                     ihit,
   output cacheTypesPkg::word_t     imemLoad,
   // shared memory bus
   output logic                     ramREN,
   output logic                     ramWEN,
   output cacheTypesPkg::addr_t     ramAddr,
   output cacheTypesPkg::word_t     ramStore,
   input  cacheTypesPkg::word_t     ramLoad,
   input  cacheTypesPkg::ramState_t ramState
);
   import cacheTypesPkg::*;

   cacheReq_t  dReq;
   cacheReq_t  iReq;
   cacheResp_t dResp;
   cacheResp_t iResp;

   dataCache i_dataCache (
      .CLK       (CLK),
      .nRST      (nRST),
      .dmemREN   (dmemREN),
      .dmemWEN   (dmemWEN),
      .dmemAddr  (dmemAddr),
      .dmemStore (dmemStore),
      .dhit      (dhit),
      .dmemLoad  (dmemLoad),
      .dReq      (dReq),
      .dResp     (dResp)
   );

   instrCache i_instrCache (
      .CLK      (CLK),
      .nRST     (nRST),
      .imemREN  (imemREN),
      .imemAddr (imemAddr),
      .ihit     (ihit),
      .imemLoad (imemLoad),
      .iReq     (iReq),
      .iResp    (iResp)
   );

   // arbiter in front of the external bus
   memoryControl i_memoryControl (
      .CLK      (CLK),
      .nRST     (nRST),
      .dReq     (dReq),
      .iReq     (iReq),
      .dResp    (dResp),
      .iResp    (iResp),
      .ramREN   (ramREN),
      .ramWEN   (ramWEN),
      .ramAddr  (ramAddr),
      .ramStore (ramStore),
      .ramLoad  (ramLoad),
      .ramState (ramState)
   );

endmodule

// ==== cacheSystemTb.sv ====
`include "cache_config.svh"

module cacheSystemTb;
   import cacheTypesPkg::*;

   typedef struct packed {
      logic  wen;
      addr_t addr;
      word_t data;   // store data or zero on reads
   } busRec_t;

   logic      CLK;
   logic      nRST;
   logic      dmemREN;
   logic      dmemWEN;
   addr_t     dmemAddr;
   word_t     dmemStore;
   logic      dhit;
   word_t     dmemLoad;
   logic      imemREN;
   addr_t     imemAddr;
   logic      ihit;
   word_t     imemLoad;
   logic      ramREN;
   logic      ramWEN;
   addr_t     ramAddr;
   word_t     ramStore;
   word_t     ramLoad = '0;
   ramState_t ramState = ramFree;

   integer  seed = 9;
   integer  latSeed = 9;      // memory latency has its own stream
   int      valueErrors = 0;
   int      timeoutErrors = 0;
   int      waitLeft = 0;
   word_t   ram [512];        // bus side memory
   word_t   img [512];        // what the processor has written
   busRec_t dLog [$];
   busRec_t iLog [$];
   busRec_t expD [$];
   addr_t   firstAccess;
   int      resTag [2][`DSETS];
   logic    resValid [2][`DSETS];
   logic    resDirty [2][`DSETS];
   logic    lruWay [`DSETS];
   int      iTag [`ISETS];
   logic    iValid [`ISETS];
   int      n;
   logic [31:0] r;

   cacheSystem i_dut (.*);

   function automatic word_t initWord(input addr_t a);
      return (a * 32'h9E3779B1) ^ 32'hC0DE5A17;
   endfunction

   function automatic logic [8:0] memIdx(input addr_t a);
      return a[10:2];
   endfunction

   function automatic addr_t dataAddr(input int tag, input int set, input int off);
      return (tag << 6) | (set << 3) | (off << 2);
   endfunction

   initial
   begin
      CLK = 1'b0;
      forever #2 CLK = ~CLK;
   end

   // 0 to 3 busy cycles then one access cycle
   always @(negedge CLK)
   begin
      if (!nRST || !(ramREN || ramWEN) || ramState == ramAccess)
      begin
         ramState = ramFree;
         waitLeft = $unsigned($random(latSeed)) % 4;
      end
      else if (waitLeft > 0)
      begin
         ramState = ramBusy;
         waitLeft = waitLeft - 1;
      end
      else
      begin
         ramState = ramAccess;
         ramLoad  = ram[memIdx(ramAddr)];
         if (ramREN && ramWEN)
         begin
            valueErrors++;
            $display("bus read and write enables both high at %h", ramAddr);
         end
         if (ramWEN)
            ram[memIdx(ramAddr)] = ramStore;
         if (dLog.size() + iLog.size() == 0)
            firstAccess = ramAddr;
         if (ramAddr < 32'h400)   // data region below and fetch region above
            dLog.push_back({ramWEN, ramAddr, ramWEN ? ramStore : 32'h0});
         else
            iLog.push_back({ramWEN, ramAddr, ramWEN ? ramStore : 32'h0});
      end
   end

   // predicts the bus traffic of one data access and updates the model
   task automatic predictData(input logic wr, input addr_t a);
      int    tag;
      int    set;
      int    way;
      addr_t vBase;
      addr_t nBase;
      tag = int'(a >> 6);
      set = int'(a[5:3]);
      way = -1;
      if (resValid[0][set] && resTag[0][set] == tag)
         way = 0;
      else if (resValid[1][set] && resTag[1][set] == tag)
         way = 1;
      if (way < 0)
      begin
         way = int'(lruWay[set]);
         if (resValid[way][set] && resDirty[way][set])
         begin
            vBase = dataAddr(resTag[way][set], set, 0);
            expD.push_back({1'b1, vBase, img[memIdx(vBase)]});
            expD.push_back({1'b1, vBase + 32'd4, img[memIdx(vBase + 32'd4)]});
         end
         nBase = dataAddr(tag, set, 0);
         expD.push_back({1'b0, nBase, 32'h0});
         expD.push_back({1'b0, nBase + 32'd4, 32'h0});
         resTag[way][set]   = tag;
         resValid[way][set] = 1'b1;
         resDirty[way][set] = 1'b0;
      end
      lruWay[set] = (way == 0);   // other way goes next
      if (wr)
         resDirty[way][set] = 1'b1;
   endtask

   task automatic runAccess(input string name, input logic dEn, input logic wr, input addr_t da,
                            input word_t d, input logic iEn, input addr_t ia);
      int    cycles;
      int    iExp;
      int    iSet;
      logic  dGot;
      logic  iGot;
      logic  waiting;
      word_t dVal;
      word_t iVal;
      word_t expWord;
      expD.delete();
      dLog.delete();
      iLog.delete();
      expWord = img[memIdx(da)];
      iSet    = int'(ia[5:2]);
      iExp    = 0;
      if (dEn)
         predictData(wr, da);
      if (iEn && !(iValid[iSet] && iTag[iSet] == int'(ia >> 6)))
      begin
         iExp         = 1;
         iValid[iSet] = 1'b1;
         iTag[iSet]   = int'(ia >> 6);
      end
      @(negedge CLK);
      dmemREN   = dEn && !wr;
      dmemWEN   = dEn && wr;
      dmemAddr  = da;
      dmemStore = d;
      imemREN   = iEn;
      imemAddr  = ia;
      dGot      = 1'b0;
      iGot      = 1'b0;
      cycles    = 0;
      do
      begin
         #1;   // outputs settled after the falling edge
         if (dEn && !dGot && dhit)
         begin
            dGot = 1'b1;
            dVal = dmemLoad;
         end
         if (iEn && !iGot && ihit)
         begin
            iGot = 1'b1;
            iVal = imemLoad;
         end
         waiting = (dEn && !dGot) || (iEn && !iGot);
         if (waiting)
         begin
            @(negedge CLK);
            if (dGot)
            begin
               dmemREN = 1'b0;
               dmemWEN = 1'b0;
            end
            if (iGot)
               imemREN = 1'b0;
         end
         cycles++;
      end while (waiting && cycles < 200);
      if (waiting)
      begin
         timeoutErrors++;
         $display("%s: a port did not hit within 200 cycles", name);
      end
      if (dGot && !wr && dVal !== expWord)
      begin
         valueErrors++;
         $display("Fail %s data expected %h actual %h", name, expWord, dVal);
      end
      if (dGot && wr)
         img[memIdx(da)] = d;
      if (iGot && iVal !== initWord(ia))
      begin
         valueErrors++;
         $display("Fail %s fetch expected %h actual %h", name, initWord(ia), iVal);
      end
      if (dLog.size() != expD.size())
      begin
         valueErrors++;
         $display("Fail %s data bus count expected %0d actual %0d", name, expD.size(), dLog.size());
      end
      else
         for (int i = 0; i < expD.size(); i++)
            if (dLog[i] != expD[i])
            begin
               valueErrors++;
               $display("Fail %s data bus %0d expected %h actual %h", name, i, expD[i], dLog[i]);
            end
      if (iLog.size() != iExp)
      begin
         valueErrors++;
         $display("Fail %s fetch bus count expected %0d actual %0d", name, iExp, iLog.size());
      end
      else if (iExp == 1 && iLog[0] != {1'b0, ia, 32'h0})
      begin
         valueErrors++;
         $display("Fail %s fetch bus expected %h actual %h", name,
                  {1'b0, ia, 32'h0}, iLog[0]);
      end
      if (dEn && iEn && expD.size() > 0 && iExp == 1 && firstAccess >= 32'h400)
      begin
         valueErrors++;
         $display("%s: the instruction fetch took the bus ahead of the data miss", name);
      end
   endtask

   initial
   begin
      nRST      = 1'b0;
      dmemREN   = 1'b0;
      dmemWEN   = 1'b0;
      dmemAddr  = '0;
      dmemStore = '0;
      imemREN   = 1'b0;
      imemAddr  = '0;
      for (int i = 0; i < 512; i++)
      begin
         ram[memIdx(i << 2)] = initWord(i << 2);
         img[memIdx(i << 2)] = initWord(i << 2);
      end
      for (int s = 0; s < `DSETS; s++)
      begin
         resValid[0][s] = 1'b0;
         resValid[1][s] = 1'b0;
         resDirty[0][s] = 1'b0;
         resDirty[1][s] = 1'b0;
         lruWay[s]      = 1'b0;
      end
      for (int s = 0; s < `ISETS; s++)
         iValid[s] = 1'b0;
      repeat (8) @(posedge CLK);
      @(negedge CLK);
      nRST = 1'b1;

      // empty caches so both ports miss together
      for (n = 0; n < 4; n++)
         runAccess("arbitration", 1'b1, 1'b0, dataAddr(n, n, 0), '0, 1'b1, 32'h400 + n * 4);

      // tags 1, 2, 3 as A, B, C in set 5
      runAccess("lru A", 1'b1, 1'b0, dataAddr(1, 5, 0), '0, 1'b0, '0);
      runAccess("lru B write", 1'b1, 1'b1, dataAddr(2, 5, 1), 32'h1234_5678, 1'b0, '0);
      runAccess("lru A again", 1'b1, 1'b0, dataAddr(1, 5, 1), '0, 1'b0, '0);
      runAccess("lru C evicts B", 1'b1, 1'b0, dataAddr(3, 5, 0), '0, 1'b0, '0);
      runAccess("lru A hit", 1'b1, 1'b0, dataAddr(1, 5, 0), '0, 1'b0, '0);
      runAccess("lru B refetch", 1'b1, 1'b0, dataAddr(2, 5, 1), '0, 1'b0, '0);
      runAccess("fetch repeat", 1'b0, 1'b0, '0, '0, 1'b1, 32'h400);

      for (n = 0; n < 400; n++)
      begin
         r = $random(seed);
         runAccess("random", r[1:0] != 2'd2, r[1:0] == 2'd1,
                   dataAddr(int'(r[3:2]), int'(r[6:4]), int'(r[7])), $random(seed),
                   r[1:0] >= 2'd2, 32'h400 + {23'd0, r[8], r[12:9], 2'b00});
      end

      $display("errors: %0d value, %0d timeout", valueErrors, timeoutErrors);
      if (valueErrors + timeoutErrors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

// ==== cacheSystem.f ====
+incdir+.
cacheTypesPkg.sv
dataCache.sv
instrCache.sv
memoryControl.sv
cacheSystem.sv
cacheSystemTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f cacheSystem.f --top-module cacheSystemTb -o simCache
if [ $? -ne 0 ]; then
   echo "compile failed"
   exit 1
fi

./obj_dir/simCache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation run failed"
   exit 1
fi

if grep -q "Done: errors found" sim.log; then
   exit 1
fi
exit 0
